//--- Bender.yml
package:
  name: dualIssue

sources:
  - rtl/dualIssuePkg.sv
  - rtl/laneIf.sv
  - rtl/idExStage.sv
  - rtl/issueCtrl.sv
  - rtl/iterCounter.sv
  - rtl/laneAlu.sv
  - rtl/shiftAddMul.sv
  - rtl/dualIssueTop.sv
  - target: test
    files:
      - tests/tbDualIssue.sv

//--- dualIssue.f
rtl/dualIssuePkg.sv
rtl/laneIf.sv
rtl/idExStage.sv
rtl/issueCtrl.sv
rtl/iterCounter.sv
rtl/laneAlu.sv
rtl/shiftAddMul.sv
rtl/dualIssueTop.sv
tests/tbDualIssue.sv

//--- rtl/dualIssuePkg.sv
package dualIssuePkg;

    localparam int DataWidth = 32;
    localparam int RegAddrWidth = 5;
    localparam int MulBitsPerStep = 2;
    localparam int MulSteps = DataWidth / MulBitsPerStep;
    localparam int StepCountWidth = 4;                      // holds 0 .. MulSteps-1

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLT = 4'd5,
        SLL = 4'd6,
        MUL = 4'd7                                          // master lane only
    } aluOpT;

    typedef struct packed {
        aluOpT                   aluOp;
        logic                    regWen;
        logic [RegAddrWidth-1:0] waddr;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [DataWidth-1:0]    rsValue;
        logic [DataWidth-1:0]    rtValue;
        logic [DataWidth-1:0]    imm;
        logic                    useImm;
    } masterInstT;

    // same layout, but the decoder never steers a multiply into this slot
    typedef struct packed {
        aluOpT                   aluOp;
        logic                    regWen;
        logic [RegAddrWidth-1:0] waddr;
        logic [RegAddrWidth-1:0] rs;
        logic [RegAddrWidth-1:0] rt;
        logic [DataWidth-1:0]    rsValue;
        logic [DataWidth-1:0]    rtValue;
        logic [DataWidth-1:0]    imm;
        logic                    useImm;
    } slaveInstT;

    typedef enum logic [1:0] {
        PAIR,
        SPLIT,
        MULWAIT
    } ctrlStateT;

endpackage

//--- rtl/dualIssueTop.sv
module dualIssueTop (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic                                  inValid,
    output logic                                  inReady,
    input  dualIssuePkg::aluOpT                   masterAluOp,
    input  logic                                  masterRegWen,
    input  logic [dualIssuePkg::RegAddrWidth-1:0] masterWaddr,
    input  logic [dualIssuePkg::RegAddrWidth-1:0] masterRs,
    input  logic [dualIssuePkg::RegAddrWidth-1:0] masterRt,
    input  logic [dualIssuePkg::DataWidth-1:0]    masterRsValue,
    input  logic [dualIssuePkg::DataWidth-1:0]    masterRtValue,
    input  logic [dualIssuePkg::DataWidth-1:0]    masterImm,
    input  logic                                  masterUseImm,
    input  logic                                  slaveValid,
    input  dualIssuePkg::aluOpT                   slaveAluOp,
    input  logic                                  slaveRegWen,
    input  logic [dualIssuePkg::RegAddrWidth-1:0] slaveWaddr,
    input  logic [dualIssuePkg::RegAddrWidth-1:0] slaveRs,
    input  logic [dualIssuePkg::RegAddrWidth-1:0] slaveRt,
    input  logic [dualIssuePkg::DataWidth-1:0]    slaveRsValue,
    input  logic [dualIssuePkg::DataWidth-1:0]    slaveRtValue,
    input  logic [dualIssuePkg::DataWidth-1:0]    slaveImm,
    input  logic                                  slaveUseImm,
    output logic                                  masterResValid,
    output logic [dualIssuePkg::DataWidth-1:0]    masterResult,
    output logic [dualIssuePkg::RegAddrWidth-1:0] masterResWaddr,
    output logic                                  slaveResValid,
    output logic [dualIssuePkg::DataWidth-1:0]    slaveResult,
    output logic [dualIssuePkg::RegAddrWidth-1:0] slaveResWaddr
);

    laneIf #(.payloadT(dualIssuePkg::masterInstT)) masterLane ();
    laneIf #(.payloadT(dualIssuePkg::slaveInstT))  slaveLane ();

    logic [dualIssuePkg::DataWidth-1:0] masterAluB;
    logic [dualIssuePkg::DataWidth-1:0] slaveAluB;
    logic [dualIssuePkg::DataWidth-1:0] masterAluRes;
    logic [dualIssuePkg::DataWidth-1:0] mulB;
    logic [dualIssuePkg::DataWidth-1:0] product;
    logic                               mulStart;
    logic                               mulBusy;
    logic                               mulLast;

    assign masterLane.payload = '{aluOp: masterAluOp, regWen: masterRegWen,
        waddr: masterWaddr, rs: masterRs, rt: masterRt, rsValue: masterRsValue,
        rtValue: masterRtValue, imm: masterImm, useImm: masterUseImm};
    assign slaveLane.payload = '{aluOp: slaveAluOp, regWen: slaveRegWen,
        waddr: slaveWaddr, rs: slaveRs, rt: slaveRt, rsValue: slaveRsValue,
        rtValue: slaveRtValue, imm: slaveImm, useImm: slaveUseImm};

    issueCtrl issueCtrl_i (.clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
        .slaveValid(slaveValid), .masterLane(masterLane), .slaveLane(slaveLane),
        .mulStart(mulStart), .mulLast(mulLast));

    idExStage #(.payloadT(dualIssuePkg::masterInstT)) masterStage_i (
        .clk(clk), .rstN(rstN), .lane(masterLane));
    idExStage #(.payloadT(dualIssuePkg::slaveInstT)) slaveStage_i (
        .clk(clk), .rstN(rstN), .lane(slaveLane));

    assign masterAluB = masterLane.stagePayload.useImm ? masterLane.stagePayload.imm
                                                       : masterLane.stagePayload.rtValue;
    assign slaveAluB  = slaveLane.stagePayload.useImm ? slaveLane.stagePayload.imm
                                                      : slaveLane.stagePayload.rtValue;

    laneAlu masterAlu_i (.op(masterLane.stagePayload.aluOp),
        .a(masterLane.stagePayload.rsValue), .b(masterAluB), .result(masterAluRes));
    laneAlu slaveAlu_i (.op(slaveLane.stagePayload.aluOp),
        .a(slaveLane.stagePayload.rsValue), .b(slaveAluB), .result(slaveResult));

    // multiplier takes its operands straight from the ports on the accepting edge
    assign mulB = masterUseImm ? masterImm : masterRtValue;

    shiftAddMul mul_i (.clk(clk), .rstN(rstN), .start(mulStart), .a(masterRsValue),
        .b(mulB), .step(mulBusy), .product(product));
    iterCounter mulCounter_i (.clk(clk), .rstN(rstN), .start(mulStart), .busy(mulBusy),
        .last(mulLast));

    assign masterResValid = masterLane.valid && !masterLane.stall;  // hidden while multiplying
    assign masterResult   = (masterLane.stagePayload.aluOp == dualIssuePkg::MUL) ? product
                                                                             : masterAluRes;
    assign slaveResValid  = slaveLane.valid;

    // r0 when the lane does not write back
    assign masterResWaddr = masterLane.stagePayload.regWen ? masterLane.stagePayload.waddr : '0;
    assign slaveResWaddr  = slaveLane.stagePayload.regWen ? slaveLane.stagePayload.waddr : '0;

endmodule

//--- rtl/idExStage.sv
module idExStage #(
    parameter type payloadT = logic
) (
    input logic  clk,
    input logic  rstN,
    laneIf.stage lane
);

    payloadT heldQ;
    logic    validQ;

    always_ff @(posedge clk) begin
        if (!rstN || lane.clear) begin
            heldQ <= '0;                                    // bubble
        end else if (lane.ena) begin
            heldQ <= lane.payload;
        end
    end

    // a stalled lane keeps its valid so the pending multiply stays visible
    always_ff @(posedge clk) begin
        if (!rstN || lane.clear) begin
            validQ <= 1'b0;
        end else if (!lane.stall) begin
            validQ <= lane.ena;
        end
    end

    assign lane.stagePayload = heldQ;
    assign lane.valid        = validQ;

    payloadStableInStall: assert property (
        @(posedge clk) disable iff (!rstN)
        lane.stall |=> $stable(lane.stagePayload)
    );

endmodule

//--- rtl/issueCtrl.sv
module issueCtrl (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    output logic inReady,
    input  logic slaveValid,
    laneIf.ctrl  masterLane,
    laneIf.ctrl  slaveLane,
    output logic mulStart,
    input  logic mulLast
);

    dualIssuePkg::ctrlStateT state;
    dualIssuePkg::ctrlStateT stateNext;
    logic readyQ;
    logic slavePendingQ;                                    // slave waits behind a multiply
    logic accept;
    logic isMul;
    logic conflict;

    assign accept  = inValid && readyQ;
    assign inReady = readyQ;
    assign isMul   = masterLane.payload.aluOp == dualIssuePkg::MUL;

    // slave reads what the master writes, r0 excluded
    assign conflict = slaveValid && masterLane.payload.regWen
        && (masterLane.payload.waddr != '0)
        && ((slaveLane.payload.rs == masterLane.payload.waddr)
            || (slaveLane.payload.rt == masterLane.payload.waddr));

    always_comb begin
        stateNext        = state;
        masterLane.ena   = 1'b0;
        masterLane.clear = 1'b0;
        masterLane.stall = 1'b0;
        slaveLane.ena    = 1'b0;
        slaveLane.clear  = 1'b0;
        slaveLane.stall  = 1'b0;                            // slave never holds
        mulStart         = 1'b0;
        case (state)
            dualIssuePkg::PAIR: begin
                if (accept) begin
                    masterLane.ena  = 1'b1;
                    slaveLane.ena   = slaveValid && !conflict;
                    slaveLane.clear = conflict;
                    mulStart        = isMul;
                    if (isMul) begin
                        stateNext = dualIssuePkg::MULWAIT;
                    end else if (conflict) begin
                        stateNext = dualIssuePkg::SPLIT;
                    end
                end
            end
            dualIssuePkg::SPLIT: begin
                slaveLane.ena    = 1'b1;                    // inputs still held by source
                masterLane.clear = 1'b1;
                stateNext        = dualIssuePkg::PAIR;
            end
            dualIssuePkg::MULWAIT: begin
                masterLane.stall = 1'b1;
                if (mulLast) begin
                    stateNext = slavePendingQ ? dualIssuePkg::SPLIT : dualIssuePkg::PAIR;
                end
            end
            default: begin
                stateNext = dualIssuePkg::PAIR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state         <= dualIssuePkg::PAIR;
            readyQ        <= 1'b0;
            slavePendingQ <= 1'b0;
        end else begin
            state  <= stateNext;
            readyQ <= stateNext == dualIssuePkg::PAIR;
            if (mulStart) begin
                slavePendingQ <= conflict;
            end
        end
    end

    noSlaveMul: assert property (
        @(posedge clk) disable iff (!rstN)
        slaveLane.ena |-> slaveLane.payload.aluOp != dualIssuePkg::MUL
    );

    masterEnaClearExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(masterLane.ena && masterLane.clear)
    );

    slaveEnaClearExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(slaveLane.ena && slaveLane.clear)
    );

endmodule

//--- rtl/iterCounter.sv
module iterCounter (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    output logic busy,
    output logic last
);

    logic [dualIssuePkg::StepCountWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start && !busy) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
            end
            count <= count + 1'b1;                          // wraps back to zero after last
        end
    end

    assign last = busy
        && (count == dualIssuePkg::StepCountWidth'(dualIssuePkg::MulSteps - 1));

endmodule

//--- rtl/laneAlu.sv
module laneAlu (
    input  dualIssuePkg::aluOpT                op,
    input  logic [dualIssuePkg::DataWidth-1:0] a,
    input  logic [dualIssuePkg::DataWidth-1:0] b,
    output logic [dualIssuePkg::DataWidth-1:0] result
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            dualIssuePkg::ADD: begin
                result = a + b;
            end
            dualIssuePkg::SUB: begin
                result = a - b;
            end
            dualIssuePkg::AND: begin
                result = a & b;
            end
            dualIssuePkg::OR: begin
                result = a | b;
            end
            dualIssuePkg::XOR: begin
                result = a ^ b;
            end
            dualIssuePkg::SLT: begin
                result = {{(dualIssuePkg::DataWidth - 1){1'b0}}, lessThan};
            end
            dualIssuePkg::SLL: begin
                result = a << b[4:0];                       // shamt from low bits only
            end
            default: begin
                result = '0;                                // MUL result comes from shiftAddMul
            end
        endcase
    end

endmodule

//--- rtl/laneIf.sv
interface laneIf #(
    parameter type payloadT = logic
);

    payloadT payload;                                       // decoded instruction offered to the stage
    payloadT stagePayload;                                  // registered copy seen by execute
    logic    ena;
    logic    clear;
    logic    valid;
    logic    stall;

    modport ctrl (
        input  payload,
        input  valid,
        output ena,
        output clear,
        output stall
    );

    modport stage (
        input  payload,
        input  ena,
        input  clear,
        input  stall,
        output valid,
        output stagePayload
    );

endinterface

//--- rtl/shiftAddMul.sv
module shiftAddMul (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               start,
    input  logic [dualIssuePkg::DataWidth-1:0] a,
    input  logic [dualIssuePkg::DataWidth-1:0] b,
    input  logic                               step,
    output logic [dualIssuePkg::DataWidth-1:0] product
);

    logic [dualIssuePkg::DataWidth-1:0] mcandQ;
    logic [dualIssuePkg::DataWidth-1:0] mplierQ;
    logic [dualIssuePkg::DataWidth-1:0] partial;

    // sum of the partial products for the low multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < dualIssuePkg::MulBitsPerStep; i++) begin
            if (mplierQ[i]) begin
                partial = partial + (mcandQ << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcandQ  <= a;
            mplierQ <= b;
        end else if (step) begin
            mcandQ  <= mcandQ << dualIssuePkg::MulBitsPerStep;
            mplierQ <= mplierQ >> dualIssuePkg::MulBitsPerStep;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            product <= '0;
        end else if (start) begin
            product <= '0;
        end else if (step) begin
            product <= product + partial;                   // upper half dropped
        end
    end

endmodule

//--- tests/tbDualIssue.sv
module tbDualIssue;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [dualIssuePkg::RegAddrWidth-1:0] waddr;
        logic [dualIssuePkg::DataWidth-1:0]    value;
    } resultT;

    logic                                  clk;
    logic                                  rstN;
    logic                                  inValid;
    logic                                  inReady;
    logic                                  slaveValid;
    dualIssuePkg::masterInstT              masterInst;
    dualIssuePkg::slaveInstT               slaveInst;
    logic                                  masterResValid;
    logic [dualIssuePkg::DataWidth-1:0]    masterResult;
    logic [dualIssuePkg::RegAddrWidth-1:0] masterResWaddr;
    logic                                  slaveResValid;
    logic [dualIssuePkg::DataWidth-1:0]    slaveResult;
    logic [dualIssuePkg::RegAddrWidth-1:0] slaveResWaddr;

    resultT masterQ[$];
    resultT slaveQ[$];
    resultT masterHead;
    resultT slaveHead;
    logic   masterHeadOk;
    logic   slaveHeadOk;
    int     cycleCount;
    int     lastMasterCycle;
    int     lastSlaveCycle;
    int     masterResCount;
    int     slaveResCount;
    int     errorCount;
    int     testsPassed;
    int     testsFailed;
    integer seed;

    dualIssueTop dualIssueTop_i (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
        .masterAluOp(masterInst.aluOp), .masterRegWen(masterInst.regWen),
        .masterWaddr(masterInst.waddr), .masterRs(masterInst.rs), .masterRt(masterInst.rt),
        .masterRsValue(masterInst.rsValue), .masterRtValue(masterInst.rtValue),
        .masterImm(masterInst.imm), .masterUseImm(masterInst.useImm),
        .slaveValid(slaveValid), .slaveAluOp(slaveInst.aluOp), .slaveRegWen(slaveInst.regWen),
        .slaveWaddr(slaveInst.waddr), .slaveRs(slaveInst.rs), .slaveRt(slaveInst.rt),
        .slaveRsValue(slaveInst.rsValue), .slaveRtValue(slaveInst.rtValue),
        .slaveImm(slaveInst.imm), .slaveUseImm(slaveInst.useImm),
        .masterResValid(masterResValid), .masterResult(masterResult),
        .masterResWaddr(masterResWaddr), .slaveResValid(slaveResValid),
        .slaveResult(slaveResult), .slaveResWaddr(slaveResWaddr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic reportFailure(input string what);
        errorCount++;
        $display("%s", what);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        errorCount++;
        $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, expected);
    endtask

    function automatic logic [31:0] refAlu(dualIssuePkg::aluOpT op, logic [31:0] a,
                                           logic [31:0] b);
        logic [63:0] full;
        full = 64'(a) * 64'(b);
        case (op)
            dualIssuePkg::ADD: return a + b;
            dualIssuePkg::SUB: return a - b;
            dualIssuePkg::AND: return a & b;
            dualIssuePkg::OR:  return a | b;
            dualIssuePkg::XOR: return a ^ b;
            dualIssuePkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            dualIssuePkg::SLL: return a << b[4:0];
            dualIssuePkg::MUL: return full[31:0];                   // low half of the product
            default:           return '0;
        endcase
    endfunction

    function automatic resultT expectFor(dualIssuePkg::masterInstT inst);
        resultT r;
        r.value = refAlu(inst.aluOp, inst.rsValue, inst.useImm ? inst.imm : inst.rtValue);
        r.waddr = inst.regWen ? inst.waddr : '0;                    // no writeback shows r0
        return r;
    endfunction

    task automatic randomInst(input dualIssuePkg::aluOpT op,
                              output dualIssuePkg::masterInstT inst);
        logic [31:0] r;
        r            = $random(seed);
        inst.aluOp   = op;
        inst.regWen  = r[0] | r[1];
        inst.waddr   = r[6:2];
        inst.rs      = r[11:7];
        inst.rt      = r[16:12];
        inst.useImm  = r[17];
        inst.rsValue = $random(seed);
        inst.rtValue = $random(seed);
        inst.imm     = $random(seed);
    endtask

    // offer one pair, hold the fields until inReady is back
    task automatic offerPair(input dualIssuePkg::masterInstT m, input dualIssuePkg::slaveInstT s,
                             input logic sValid, output int lowCycles,
                             output logic readyWithResult);
        int waited;
        lowCycles       = -1;
        readyWithResult = 1'b0;
        @(negedge clk);
        masterInst = m;
        slaveInst  = s;
        slaveValid = sValid;
        inValid    = 1'b1;
        masterQ.push_back(expectFor(m));
        if (sValid) begin
            slaveQ.push_back(expectFor(dualIssuePkg::masterInstT'(s)));
        end
        waited = 0;
        while (!inReady && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (!inReady) begin
            reportFailure("timeout: inReady never rose to take the pair");
            inValid = 1'b0;
            return;
        end
        @(negedge clk);                                             // taken on the edge just passed
        inValid   = 1'b0;
        lowCycles = 0;
        while (!inReady && lowCycles < dualIssuePkg::MulSteps + 4) begin
            @(negedge clk);
            lowCycles++;
        end
        readyWithResult = masterResValid;
        if (!inReady) begin
            reportFailure("timeout: inReady stayed low after an accepted pair");
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while ((masterQ.size() > 0 || slaveQ.size() > 0) && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (masterQ.size() > 0 || slaveQ.size() > 0) begin
            reportFailure("timeout: expected results never came out");
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    // retire results on the edge that sees them, heads move one edge later
    always @(posedge clk) begin
        if (rstN && masterResValid) begin
            masterResCount++;
            lastMasterCycle = cycleCount;
            if (masterQ.size() > 0) begin
                void'(masterQ.pop_front());
            end
        end
        if (rstN && slaveResValid) begin
            slaveResCount++;
            lastSlaveCycle = cycleCount;
            if (slaveQ.size() > 0) begin
                void'(slaveQ.pop_front());
            end
        end
        masterHeadOk <= masterQ.size() > 0;
        masterHead   <= (masterQ.size() > 0) ? masterQ[0] : '0;
        slaveHeadOk  <= slaveQ.size() > 0;
        slaveHead    <= (slaveQ.size() > 0) ? slaveQ[0] : '0;
        cycleCount++;
    end

    masterPresent: assert property (@(posedge clk) disable iff (!rstN)
        masterResValid |-> masterHeadOk)
        else reportFailure("master result valid with no instruction outstanding");
    masterValueOk: assert property (@(posedge clk) disable iff (!rstN)
        masterResValid && masterHeadOk |-> masterResult == masterHead.value)
        else reportMismatch("masterResult", $sampled(masterResult), $sampled(masterHead.value));
    masterWaddrOk: assert property (@(posedge clk) disable iff (!rstN)
        masterResValid && masterHeadOk |-> masterResWaddr == masterHead.waddr)
        else reportMismatch("masterResWaddr", $sampled(masterResWaddr),
                            $sampled(masterHead.waddr));
    slavePresent: assert property (@(posedge clk) disable iff (!rstN)
        slaveResValid |-> slaveHeadOk)
        else reportFailure("slave result valid with no instruction outstanding");
    slaveValueOk: assert property (@(posedge clk) disable iff (!rstN)
        slaveResValid && slaveHeadOk |-> slaveResult == slaveHead.value)
        else reportMismatch("slaveResult", $sampled(slaveResult), $sampled(slaveHead.value));
    slaveWaddrOk: assert property (@(posedge clk) disable iff (!rstN)
        slaveResValid && slaveHeadOk |-> slaveResWaddr == slaveHead.waddr)
        else reportMismatch("slaveResWaddr", $sampled(slaveResWaddr), $sampled(slaveHead.waddr));

    initial begin
        int                       lowCycles;
        logic                     readyWithResult;
        int                       errorsBefore;
        int                       masterBefore;
        int                       slaveBefore;
        int                       waited;
        dualIssuePkg::masterInstT m;
        dualIssuePkg::masterInstT s;
        seed           = 32'h62b3;
        rstN           = 1'b0;
        inValid        = 1'b0;
        slaveValid     = 1'b0;
        masterInst     = '0;
        slaveInst      = '0;
        cycleCount     = 0;
        masterResCount = 0;
        slaveResCount  = 0;
        errorCount     = 0;
        testsPassed    = 0;
        testsFailed    = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        errorsBefore = errorCount;
        assert (!inReady && !masterResValid && !slaveResValid)
            else reportFailure("outputs not idle right after reset");
        waited = 0;
        while (!inReady && waited < 5) begin
            @(negedge clk);
            waited++;
        end
        assert (inReady) else reportFailure("timeout: inReady never rose after reset");
        repeat (4) begin
            @(negedge clk);
            assert (!masterResValid && !slaveResValid)
                else reportFailure("result valid while no pair was offered");
        end
        finishTest("reset", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 21; i++) begin
            randomInst(dualIssuePkg::aluOpT'(i % 7), m);
            randomInst(dualIssuePkg::aluOpT'((i + 3) % 7), s);
            m.waddr[4] = 1'b0;                                      // master writes r0..r15
            s.rs[4]    = 1'b1;                                      // slave reads r16..r31
            s.rt[4]    = 1'b1;
            offerPair(m, dualIssuePkg::slaveInstT'(s), 1'b1, lowCycles, readyWithResult);
            assert (lowCycles == 0) else reportFailure("independent pair was split");
        end
        waitDrain();
        finishTest("independent pairs", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 2; i++) begin
            randomInst(dualIssuePkg::aluOpT'(i + 2), m);
            randomInst(dualIssuePkg::ADD, s);
            m.regWen = 1'b1;
            m.waddr  = 5'd9;
            s.rs     = (i == 0) ? 5'd9 : 5'd3;                      // rs hazard, then rt hazard
            s.rt     = (i == 0) ? 5'd4 : 5'd9;
            offerPair(m, dualIssuePkg::slaveInstT'(s), 1'b1, lowCycles, readyWithResult);
            assert (lowCycles == 1) else reportFailure("split pair did not stall inReady once");
            waitDrain();
            assert (lastMasterCycle < lastSlaveCycle)
                else reportFailure("slave result did not trail the master result");
        end
        finishTest("conflicting pairs", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 3; i++) begin
            randomInst(dualIssuePkg::MUL, m);
            randomInst(dualIssuePkg::aluOpT'(i * 2), s);
            m.useImm   = i[0];
            m.waddr[4] = 1'b0;
            s.rs[4]    = 1'b1;
            s.rt[4]    = 1'b1;
            offerPair(m, dualIssuePkg::slaveInstT'(s), 1'b1, lowCycles, readyWithResult);
            assert (readyWithResult) else reportFailure("inReady came back before the product");
            assert (lowCycles >= 1 && lowCycles <= dualIssuePkg::MulSteps + 2)
                else reportFailure("multiply stall length out of bounds");
            waitDrain();
            assert (lastSlaveCycle < lastMasterCycle)
                else reportFailure("slave result held back by the multiply");
        end
        finishTest("multiply", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < 4; i++) begin
            randomInst(dualIssuePkg::aluOpT'(i + 1), m);
            randomInst(dualIssuePkg::ADD, s);
            masterBefore = masterResCount;
            slaveBefore  = slaveResCount;
            offerPair(m, dualIssuePkg::slaveInstT'(s), 1'b0, lowCycles, readyWithResult);
            waitDrain();
            repeat (3) @(negedge clk);                              // give a stray result room
            assert (masterResCount == masterBefore + 1 && slaveResCount == slaveBefore)
                else reportFailure("lone master did not give exactly one master result");
        end
        finishTest("lone master", errorsBefore);

        $display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
